// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = checkpoint_array_tb
FILELIST  = build.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = Regression passed

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator, run the testbench and check the log"
	@echo "make clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
hdl/core_types_pkg.sv
hdl/branch_types_pkg.sv
hdl/checkpoint_save_if.sv
hdl/checkpoint_free_list.sv
hdl/checkpoint_array.sv
hdl/checkpoint_array_wrapper.sv
test/checkpoint_array_assertions.sv
test/checkpoint_array_tb.sv

// ==== hdl/branch_types_pkg.sv ====
package branch_types_pkg;

	// --------------------------------------------------
	// predictor history widths

	// per-branch local history
	parameter int LH_LENGTH = 8;

	// shared global history
	parameter int GH_LENGTH = 12;

	// return address stack pointer
	parameter int RAS_INDEX_WIDTH = 3;

	// --------------------------------------------------
	// predictor state types

	typedef logic [LH_LENGTH-1:0] lh_t;

	typedef logic [GH_LENGTH-1:0] gh_t;

	typedef logic [RAS_INDEX_WIDTH-1:0] ras_index_t;

endpackage

// ==== hdl/checkpoint_array.sv ====
`timescale 1ns/10ps

module checkpoint_array #(
	parameter int CHECKPOINT_COUNT = 8,
	parameter int CHECKPOINT_INDEX_WIDTH = $clog2(CHECKPOINT_COUNT),
	parameter int CHECKPOINT_THRESHOLD = 4
) (
	input logic CLK,
	input logic nRST,

	// snapshot save
	checkpoint_save_if.allocator save,

	// map table restore
	input logic [CHECKPOINT_INDEX_WIDTH-1:0] map_table_restore_index,
	output core_types_pkg::map_table_t map_table_restore_map_table,

	// branch info restore
	input logic [CHECKPOINT_INDEX_WIDTH-1:0] branch_info_restore_index,
	output branch_types_pkg::lh_t branch_info_restore_lh,
	output branch_types_pkg::gh_t branch_info_restore_gh,
	output branch_types_pkg::ras_index_t branch_info_restore_ras_index,

	// slot release on branch resolve
	input logic clear_valid,
	input logic [CHECKPOINT_INDEX_WIDTH-1:0] clear_index,

	output logic above_threshold
);

	import core_types_pkg::*;
	import branch_types_pkg::*;

	// --------------------------------------------------
	// storage

	// separate arrays keep the two read ports independent
	map_table_t map_table_array [CHECKPOINT_COUNT];
	lh_t lh_array [CHECKPOINT_COUNT];
	gh_t gh_array [CHECKPOINT_COUNT];
	ras_index_t ras_index_array [CHECKPOINT_COUNT];

	logic save_fire;

	// --------------------------------------------------
	// slot allocation

	assign save_fire = save.valid & save.ready;

	checkpoint_free_list #(
		.CHECKPOINT_COUNT(CHECKPOINT_COUNT),
		.CHECKPOINT_INDEX_WIDTH(CHECKPOINT_INDEX_WIDTH),
		.CHECKPOINT_THRESHOLD(CHECKPOINT_THRESHOLD)
	) free_list (
		.CLK(CLK),
		.nRST(nRST),
		.alloc(save_fire),
		.alloc_ready(save.ready),
		.alloc_index(save.index),
		.clear_valid(clear_valid),
		.clear_index(clear_index),
		.above_threshold(above_threshold)
	);

	// --------------------------------------------------
	// write on accepted save

	always_ff @(posedge CLK) begin
		if (save_fire) begin
			map_table_array[save.index] <= save.map_table;
		end
	end

	always_ff @(posedge CLK) begin
		if (save_fire) begin
			lh_array[save.index] <= save.lh;
			gh_array[save.index] <= save.gh;
			ras_index_array[save.index] <= save.ras_index;
		end
	end

	// --------------------------------------------------
	// restore reads

	// old contents are seen when the slot is written at the same edge
	assign map_table_restore_map_table = map_table_array[map_table_restore_index];

	assign branch_info_restore_lh = lh_array[branch_info_restore_index];
	assign branch_info_restore_gh = gh_array[branch_info_restore_index];
	assign branch_info_restore_ras_index = ras_index_array[branch_info_restore_index];

endmodule

// ==== hdl/checkpoint_array_wrapper.sv ====
`timescale 1ns/10ps

module checkpoint_array_wrapper #(
	parameter int CHECKPOINT_COUNT = 8,
	parameter int CHECKPOINT_INDEX_WIDTH = $clog2(CHECKPOINT_COUNT),
	parameter int CHECKPOINT_THRESHOLD = 4
) (
	input logic CLK,
	input logic nRST,

	// snapshot save
	input logic next_save_valid,
	input core_types_pkg::map_table_t next_save_map_table,
	input branch_types_pkg::lh_t next_save_lh,
	input branch_types_pkg::gh_t next_save_gh,
	input branch_types_pkg::ras_index_t next_save_ras_index,

	output logic last_save_ready,
	output logic [CHECKPOINT_INDEX_WIDTH-1:0] last_save_index,

	// map table restore
	input logic [CHECKPOINT_INDEX_WIDTH-1:0] next_map_table_restore_index,
	output core_types_pkg::map_table_t last_map_table_restore_map_table,

	// branch info restore
	input logic [CHECKPOINT_INDEX_WIDTH-1:0] next_branch_info_restore_index,
	output branch_types_pkg::lh_t last_branch_info_restore_lh,
	output branch_types_pkg::gh_t last_branch_info_restore_gh,
	output branch_types_pkg::ras_index_t last_branch_info_restore_ras_index,

	// slot release
	input logic next_clear_valid,
	input logic [CHECKPOINT_INDEX_WIDTH-1:0] next_clear_index,

	// free slot level for the front end stall
	output logic last_above_threshold
);

	import core_types_pkg::*;
	import branch_types_pkg::*;

	// --------------------------------------------------
	// array side signals

	checkpoint_save_if #(
		.CHECKPOINT_INDEX_WIDTH(CHECKPOINT_INDEX_WIDTH)
	) save_if ();

	logic [CHECKPOINT_INDEX_WIDTH-1:0] map_table_restore_index;
	map_table_t map_table_restore_map_table;

	logic [CHECKPOINT_INDEX_WIDTH-1:0] branch_info_restore_index;
	lh_t branch_info_restore_lh;
	gh_t branch_info_restore_gh;
	ras_index_t branch_info_restore_ras_index;

	logic clear_valid;
	logic [CHECKPOINT_INDEX_WIDTH-1:0] clear_index;

	logic above_threshold;

	checkpoint_array #(
		.CHECKPOINT_COUNT(CHECKPOINT_COUNT),
		.CHECKPOINT_INDEX_WIDTH(CHECKPOINT_INDEX_WIDTH),
		.CHECKPOINT_THRESHOLD(CHECKPOINT_THRESHOLD)
	) array (
		.CLK(CLK),
		.nRST(nRST),
		.save(save_if.allocator),
		.map_table_restore_index(map_table_restore_index),
		.map_table_restore_map_table(map_table_restore_map_table),
		.branch_info_restore_index(branch_info_restore_index),
		.branch_info_restore_lh(branch_info_restore_lh),
		.branch_info_restore_gh(branch_info_restore_gh),
		.branch_info_restore_ras_index(branch_info_restore_ras_index),
		.clear_valid(clear_valid),
		.clear_index(clear_index),
		.above_threshold(above_threshold)
	);

	// --------------------------------------------------
	// input stage

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			save_if.valid <= 1'b0;
			save_if.map_table <= '0;
			save_if.lh <= '0;
			save_if.gh <= '0;
			save_if.ras_index <= '0;
			map_table_restore_index <= '0;
			branch_info_restore_index <= '0;
			clear_valid <= 1'b0;
			clear_index <= '0;
		end else begin
			save_if.valid <= next_save_valid;
			save_if.map_table <= next_save_map_table;
			save_if.lh <= next_save_lh;
			save_if.gh <= next_save_gh;
			save_if.ras_index <= next_save_ras_index;
			map_table_restore_index <= next_map_table_restore_index;
			branch_info_restore_index <= next_branch_info_restore_index;
			clear_valid <= next_clear_valid;
			clear_index <= next_clear_index;
		end
	end

	// --------------------------------------------------
	// output stage

	// save response lines up with the save it belongs to
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			last_save_ready <= 1'b0;
			last_save_index <= '0;
			last_map_table_restore_map_table <= '0;
			last_branch_info_restore_lh <= '0;
			last_branch_info_restore_gh <= '0;
			last_branch_info_restore_ras_index <= '0;
			last_above_threshold <= 1'b0;
		end else begin
			last_save_ready <= save_if.ready;
			last_save_index <= save_if.index;
			last_map_table_restore_map_table <= map_table_restore_map_table;
			last_branch_info_restore_lh <= branch_info_restore_lh;
			last_branch_info_restore_gh <= branch_info_restore_gh;
			last_branch_info_restore_ras_index <= branch_info_restore_ras_index;
			last_above_threshold <= above_threshold;
		end
	end

endmodule

// ==== hdl/checkpoint_free_list.sv ====
`timescale 1ns/10ps

module checkpoint_free_list #(
	parameter int CHECKPOINT_COUNT = 8,
	parameter int CHECKPOINT_INDEX_WIDTH = $clog2(CHECKPOINT_COUNT),
	parameter int CHECKPOINT_THRESHOLD = 4
) (
	input logic CLK,
	input logic nRST,

	// allocation, taken only when alloc_ready is high
	input logic alloc,
	output logic alloc_ready,
	output logic [CHECKPOINT_INDEX_WIDTH-1:0] alloc_index,

	// release of a slot
	input logic clear_valid,
	input logic [CHECKPOINT_INDEX_WIDTH-1:0] clear_index,

	output logic above_threshold
);

	typedef logic [CHECKPOINT_INDEX_WIDTH-1:0] slot_index_t;
	typedef logic [$clog2(CHECKPOINT_COUNT+1)-1:0] free_count_t;

	logic [CHECKPOINT_COUNT-1:0] occupied;
	logic [CHECKPOINT_COUNT-1:0] next_occupied;
	free_count_t free_count;
	free_count_t next_free_count;
	logic clear_hit;

	// --------------------------------------------------
	// lowest free slot

	always_comb begin
		alloc_index = '0;
		// walk down so the lowest free slot is the last one kept
		for (int i = CHECKPOINT_COUNT - 1; i >= 0; i--) begin
			if (!occupied[i]) begin
				alloc_index = slot_index_t'(i);
			end
		end
	end

	assign alloc_ready = ~&occupied;

	// a clear only counts when its slot is actually held
	assign clear_hit = clear_valid & occupied[clear_index];

	// --------------------------------------------------
	// occupancy and free count update

	always_comb begin
		next_occupied = occupied;
		next_free_count = free_count;
		// clear first, alloc index came from the old occupancy
		if (clear_hit) begin
			next_occupied[clear_index] = 1'b0;
		end
		if (alloc) begin
			next_occupied[alloc_index] = 1'b1;
		end
		case ({alloc, clear_hit})
			2'b10: next_free_count = free_count - free_count_t'(1);
			2'b01: next_free_count = free_count + free_count_t'(1);
			default: next_free_count = free_count;
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			occupied <= '0;
			free_count <= free_count_t'(CHECKPOINT_COUNT);
		end else begin
			occupied <= next_occupied;
			free_count <= next_free_count;
		end
	end

	assign above_threshold = free_count >= free_count_t'(CHECKPOINT_THRESHOLD);

endmodule

// ==== hdl/checkpoint_save_if.sv ====
`timescale 1ns/10ps

interface checkpoint_save_if #(
	parameter int CHECKPOINT_INDEX_WIDTH = 3
) ();

	import core_types_pkg::*;
	import branch_types_pkg::*;

	// request side, one snapshot per cycle
	logic valid;
	map_table_t map_table;
	lh_t lh;
	gh_t gh;
	ras_index_t ras_index;

	// response, valid in the same cycle as the request
	logic ready;
	logic [CHECKPOINT_INDEX_WIDTH-1:0] index;

	modport requester (
		output valid, map_table, lh, gh, ras_index,
		input ready, index
	);

	modport allocator (
		input valid, map_table, lh, gh, ras_index,
		output ready, index
	);

endinterface

// ==== hdl/core_types_pkg.sv ====
package core_types_pkg;

	// --------------------------------------------------
	// architectural and physical register space

	// registers visible to software
	parameter int AR_COUNT = 32;

	// physical register tag width
	parameter int LOG_PR_COUNT = 7;

	// --------------------------------------------------
	// rename types

	// one physical register tag
	typedef logic [LOG_PR_COUNT-1:0] pr_tag_t;

	// full rename map, one tag per architectural register
	// entry i holds the tag for architectural register i
	typedef pr_tag_t [AR_COUNT-1:0] map_table_t;

endpackage

// ==== test/checkpoint_array_assertions.sv ====
`timescale 1ns/10ps

module checkpoint_array_assertions #(
	parameter int CHECKPOINT_COUNT = 8,
	parameter int CHECKPOINT_INDEX_WIDTH = $clog2(CHECKPOINT_COUNT),
	parameter int CHECKPOINT_THRESHOLD = 4
) (
	input logic CLK,
	input logic nRST,
	input logic save_valid,
	input logic save_ready,
	input logic [CHECKPOINT_INDEX_WIDTH-1:0] save_index,
	input logic clear_valid,
	input logic [CHECKPOINT_INDEX_WIDTH-1:0] clear_index,
	input logic [CHECKPOINT_COUNT-1:0] occupied,
	input logic above_threshold
);

	int free_slots;

	assign free_slots = CHECKPOINT_COUNT - $countones(occupied);

	// --------------------------------------------------
	// allocation rules

	full_no_ready: assert property (@(posedge CLK) disable iff (!nRST)
		&occupied |-> !save_ready)
		else $error("save ready high while every slot is occupied");

	offer_is_free: assert property (@(posedge CLK) disable iff (!nRST)
		save_ready |-> !occupied[save_index])
		else $error("offered slot is already occupied");

	// --------------------------------------------------
	// clear and free level

	// a same-cycle save may take the cleared slot again
	clear_frees: assert property (@(posedge CLK) disable iff (!nRST)
		clear_valid && !(save_valid && save_ready && save_index == clear_index)
		|=> !occupied[$past(clear_index)])
		else $error("cleared slot still occupied one cycle later");

	threshold_level: assert property (@(posedge CLK) disable iff (!nRST)
		above_threshold == (free_slots >= CHECKPOINT_THRESHOLD))
		else $error("above threshold flag disagrees with the free count");

endmodule

bind checkpoint_array checkpoint_array_assertions #(
	.CHECKPOINT_COUNT(CHECKPOINT_COUNT),
	.CHECKPOINT_INDEX_WIDTH(CHECKPOINT_INDEX_WIDTH),
	.CHECKPOINT_THRESHOLD(CHECKPOINT_THRESHOLD)
) assertions (
	.CLK(CLK),
	.nRST(nRST),
	.save_valid(save.valid),
	.save_ready(save.ready),
	.save_index(save.index),
	.clear_valid(clear_valid),
	.clear_index(clear_index),
	.occupied(free_list.occupied),
	.above_threshold(above_threshold)
);

// ==== test/checkpoint_array_tb.sv ====
`timescale 1ns/10ps

module checkpoint_array_tb;

	import core_types_pkg::*;
	import branch_types_pkg::*;

	localparam int CHECKPOINT_COUNT = 8;
	localparam int CHECKPOINT_INDEX_WIDTH = $clog2(CHECKPOINT_COUNT);
	localparam int CHECKPOINT_THRESHOLD = 4;

	localparam int PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam int RANDOM_CYCLES = 400;
	// all directed tests fit well inside six passes over the slots
	localparam int TEST_CYCLES = RESET_CYCLES + 6 * CHECKPOINT_COUNT + RANDOM_CYCLES + 40;
	localparam int TIMEOUT_NS = (TEST_CYCLES + 50) * PERIOD;
	localparam logic [31:0] SEED = 32'hfec9da8a;

	typedef logic [CHECKPOINT_INDEX_WIDTH-1:0] slot_index_t;

	// response expected two edges after a request
	typedef struct packed {
		logic ready;
		slot_index_t index;
		logic map_known;
		map_table_t map_table;
		logic branch_known;
		lh_t lh;
		gh_t gh;
		ras_index_t ras_index;
		logic above;
	} expected_t;

	logic CLK;
	logic nRST;
	logic next_save_valid;
	map_table_t next_save_map_table;
	lh_t next_save_lh;
	gh_t next_save_gh;
	ras_index_t next_save_ras_index;
	logic last_save_ready;
	slot_index_t last_save_index;
	slot_index_t next_map_table_restore_index;
	map_table_t last_map_table_restore_map_table;
	slot_index_t next_branch_info_restore_index;
	lh_t last_branch_info_restore_lh;
	gh_t last_branch_info_restore_gh;
	ras_index_t last_branch_info_restore_ras_index;
	logic next_clear_valid;
	slot_index_t next_clear_index;
	logic last_above_threshold;

	// reference model
	logic [CHECKPOINT_COUNT-1:0] model_occupied;
	logic [CHECKPOINT_COUNT-1:0] model_written;
	map_table_t model_map_table [CHECKPOINT_COUNT];
	lh_t model_lh [CHECKPOINT_COUNT];
	gh_t model_gh [CHECKPOINT_COUNT];
	ras_index_t model_ras_index [CHECKPOINT_COUNT];
	int model_free_count;

	expected_t expected_q [$];

	int check_count = 0;
	int error_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	initial CLK = 1'b0;
	always #(PERIOD / 2) CLK = ~CLK;

	checkpoint_array_wrapper dut (
		.CLK(CLK),
		.nRST(nRST),
		.next_save_valid(next_save_valid),
		.next_save_map_table(next_save_map_table),
		.next_save_lh(next_save_lh),
		.next_save_gh(next_save_gh),
		.next_save_ras_index(next_save_ras_index),
		.last_save_ready(last_save_ready),
		.last_save_index(last_save_index),
		.next_map_table_restore_index(next_map_table_restore_index),
		.last_map_table_restore_map_table(last_map_table_restore_map_table),
		.next_branch_info_restore_index(next_branch_info_restore_index),
		.last_branch_info_restore_lh(last_branch_info_restore_lh),
		.last_branch_info_restore_gh(last_branch_info_restore_gh),
		.last_branch_info_restore_ras_index(last_branch_info_restore_ras_index),
		.next_clear_valid(next_clear_valid),
		.next_clear_index(next_clear_index),
		.last_above_threshold(last_above_threshold)
	);

	// --------------------------------------------------
	// model helpers

	function automatic slot_index_t lowest_free();
		slot_index_t found;
		logic seen;
		found = '0;
		seen = 1'b0;
		for (int i = 0; i < CHECKPOINT_COUNT; i++) begin
			if (!seen && !model_occupied[i]) begin
				found = slot_index_t'(i);
				seen = 1'b1;
			end
		end
		return found;
	endfunction

	function automatic slot_index_t random_slot();
		return slot_index_t'($urandom_range(CHECKPOINT_COUNT - 1, 0));
	endfunction

	function automatic map_table_t random_map_table();
		map_table_t map_table;
		for (int i = 0; i < AR_COUNT; i++) begin
			map_table[i] = pr_tag_t'($urandom);
		end
		return map_table;
	endfunction

	// predicts the response from the state left by all earlier requests,
	// then applies this request to the model
	task automatic model_request(input logic save_valid, input logic clear_valid,
			input slot_index_t clear_index, input slot_index_t map_index,
			input slot_index_t branch_index, input map_table_t map_table,
			input lh_t lh, input gh_t gh, input ras_index_t ras_index);
		expected_t exp;
		exp.ready = model_free_count != 0;
		exp.index = lowest_free();
		exp.map_known = model_written[map_index];
		exp.map_table = model_map_table[map_index];
		exp.branch_known = model_written[branch_index];
		exp.lh = model_lh[branch_index];
		exp.gh = model_gh[branch_index];
		exp.ras_index = model_ras_index[branch_index];
		exp.above = model_free_count >= CHECKPOINT_THRESHOLD;
		expected_q.push_back(exp);
		if (clear_valid && model_occupied[clear_index]) begin
			model_occupied[clear_index] = 1'b0;
			model_free_count++;
		end
		// the save slot was picked before the clear
		if (save_valid && exp.ready) begin
			model_occupied[exp.index] = 1'b1;
			model_written[exp.index] = 1'b1;
			model_map_table[exp.index] = map_table;
			model_lh[exp.index] = lh;
			model_gh[exp.index] = gh;
			model_ras_index[exp.index] = ras_index;
			model_free_count--;
		end
	endtask

	task automatic compare_outputs();
		expected_t exp;
		exp = expected_q.pop_front();
		check_count++;
		assert (last_save_ready === exp.ready) else begin
			$display("Fail %0t: save ready %b, expected %b", $time, last_save_ready, exp.ready);
			error_count++;
		end
		assert (!exp.ready || last_save_index === exp.index) else begin
			$display("Fail %0t: save index %0d, expected %0d", $time, last_save_index,
				exp.index);
			error_count++;
		end
		assert (!exp.map_known || last_map_table_restore_map_table === exp.map_table) else begin
			$display("Fail %0t: map table %h, expected %h", $time,
				last_map_table_restore_map_table, exp.map_table);
			error_count++;
		end
		assert (!exp.branch_known || (last_branch_info_restore_lh === exp.lh
				&& last_branch_info_restore_gh === exp.gh
				&& last_branch_info_restore_ras_index === exp.ras_index)) else begin
			$display("Fail %0t: branch info %h/%h/%h, expected %h/%h/%h", $time,
				last_branch_info_restore_lh, last_branch_info_restore_gh,
				last_branch_info_restore_ras_index, exp.lh, exp.gh, exp.ras_index);
			error_count++;
		end
		assert (last_above_threshold === exp.above) else begin
			$display("Fail %0t: above threshold %b, expected %b", $time,
				last_above_threshold, exp.above);
			error_count++;
		end
	endtask

	// --------------------------------------------------
	// one request per falling edge

	task automatic drive_cycle(input logic save_valid, input logic clear_valid,
			input slot_index_t clear_index, input slot_index_t map_index,
			input slot_index_t branch_index);
		map_table_t map_table;
		lh_t lh;
		gh_t gh;
		ras_index_t ras_index;
		// outputs now belong to the request from two cycles ago
		if (expected_q.size() >= 2) begin
			compare_outputs();
		end
		map_table = random_map_table();
		lh = lh_t'($urandom);
		gh = gh_t'($urandom);
		ras_index = ras_index_t'($urandom);
		next_save_valid = save_valid;
		next_save_map_table = map_table;
		next_save_lh = lh;
		next_save_gh = gh;
		next_save_ras_index = ras_index;
		next_clear_valid = clear_valid;
		next_clear_index = clear_index;
		next_map_table_restore_index = map_index;
		next_branch_info_restore_index = branch_index;
		model_request(save_valid, clear_valid, clear_index, map_index, branch_index,
			map_table, lh, gh, ras_index);
		@(negedge CLK);
	endtask

	task automatic idle_cycle();
		drive_cycle(1'b0, 1'b0, '0, '0, '0);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		int errors;
		// flush the last two requests of the test
		idle_cycle();
		idle_cycle();
		errors = error_count - errors_before;
		if (errors == 0) begin
			tests_passed++;
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors);
		end
	endtask

	// --------------------------------------------------
	// tests

	task automatic fill_after_reset();
		nRST = 1'b0;
		repeat (RESET_CYCLES) @(negedge CLK);
		assert (last_save_ready === 1'b0 && last_save_index === '0
				&& last_map_table_restore_map_table === '0
				&& last_branch_info_restore_lh === '0 && last_branch_info_restore_gh === '0
				&& last_branch_info_restore_ras_index === '0
				&& last_above_threshold === 1'b0) else begin
			$display("Fail %0t: outputs not zero during reset", $time);
			error_count++;
		end
		nRST = 1'b1;
		// the idle request already held in the input stage
		model_request(1'b0, 1'b0, '0, '0, '0, '0, '0, '0, '0);
		for (int i = 0; i <= CHECKPOINT_COUNT; i++) begin
			drive_cycle(1'b1, 1'b0, '0, '0, '0);
		end
		finish_test("reset and fill", 0);
	endtask

	task automatic restore_both_ports();
		int errors_before;
		errors_before = error_count;
		for (int i = 0; i < CHECKPOINT_COUNT; i++) begin
			drive_cycle(1'b0, 1'b0, '0, slot_index_t'(i),
				slot_index_t'(CHECKPOINT_COUNT - 1 - i));
		end
		finish_test("restore both ports", errors_before);
	endtask

	task automatic clear_and_reuse();
		int errors_before;
		logic [CHECKPOINT_COUNT-1:0] picked;
		slot_index_t slot;
		errors_before = error_count;
		picked = '0;
		for (int n = 0; n < 3; n++) begin
			do begin
				slot = random_slot();
			end while (picked[slot]);
			picked[slot] = 1'b1;
			drive_cycle(1'b0, 1'b1, slot, slot, slot);
		end
		for (int n = 0; n < 3; n++) begin
			drive_cycle(1'b1, 1'b0, '0, random_slot(), random_slot());
		end
		finish_test("clear and reuse", errors_before);
	endtask

	task automatic sweep_threshold();
		int errors_before;
		errors_before = error_count;
		for (int i = 0; i < CHECKPOINT_COUNT; i++) begin
			drive_cycle(1'b0, 1'b1, slot_index_t'(i), '0, '0);
		end
		for (int i = 0; i < CHECKPOINT_COUNT; i++) begin
			drive_cycle(1'b1, 1'b0, '0, '0, '0);
		end
		finish_test("threshold", errors_before);
	endtask

	task automatic random_mix();
		int errors_before;
		logic save_valid;
		logic clear_valid;
		slot_index_t map_index;
		slot_index_t branch_index;
		errors_before = error_count;
		for (int n = 0; n < RANDOM_CYCLES; n++) begin
			save_valid = $urandom_range(99, 0) < 55;
			clear_valid = $urandom_range(99, 0) < 45;
			map_index = random_slot();
			branch_index = random_slot();
			// now and then read the slot a save is about to take
			if ($urandom_range(3, 0) == 0) begin
				map_index = lowest_free();
			end
			if ($urandom_range(3, 0) == 0) begin
				branch_index = lowest_free();
			end
			drive_cycle(save_valid, clear_valid, random_slot(), map_index, branch_index);
		end
		finish_test("random mix", errors_before);
	endtask

	// --------------------------------------------------
	// main sequence and watchdog

	initial begin
		void'($urandom(SEED));
		nRST = 1'b0;
		next_save_valid = 1'b0;
		next_save_map_table = '0;
		next_save_lh = '0;
		next_save_gh = '0;
		next_save_ras_index = '0;
		next_map_table_restore_index = '0;
		next_branch_info_restore_index = '0;
		next_clear_valid = 1'b0;
		next_clear_index = '0;
		model_occupied = '0;
		model_written = '0;
		model_free_count = CHECKPOINT_COUNT;
		fill_after_reset();
		restore_both_ports();
		clear_and_reuse();
		sweep_threshold();
		random_mix();
		$display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
			tests_passed + tests_failed, tests_passed, tests_failed, check_count, error_count);
		if (error_count == 0 && tests_failed == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("run timed out after %0d ns before all tests finished", TIMEOUT_NS);
		$display("Regression failed");
		$finish;
	end

endmodule
